//--- src/cp0Pkg.sv
package cp0Pkg;

    typedef logic [31:0] word;
    typedef logic [4:0] regIndex;
    typedef logic [4:0] excCode;
    typedef logic [5:0] irqVec;    // Lines 15..10, bit 0 is line 10

    localparam int numStages = 3;
    localparam int numIrq = 6;

    localparam regIndex regBadVAddr = 5'd8;
    localparam regIndex regCount = 5'd9;
    localparam regIndex regCompare = 5'd11;
    localparam regIndex regStatus = 5'd12;
    localparam regIndex regCause = 5'd13;
    localparam regIndex regEpc = 5'd14;
    localparam regIndex regPrId = 5'd15;

    localparam excCode causeInt = 5'd0;
    localparam excCode causeAdEL = 5'd4;
    localparam excCode causeSys = 5'd8;
    localparam excCode causeOv = 5'd12;
    localparam excCode causeEret = 5'd31;    // Never reported by hardware

    localparam word handlerAddress = 32'hbfc00380;
    localparam word prIdValue = 32'hdeadbeef;

    // Bit positions in Status and Cause
    localparam int bitIe = 0;
    localparam int bitExl = 1;
    localparam int bitBd = 31;

    localparam word statusReset = 32'h0000ff02;    // IM all ones, EXL set

    typedef struct packed {
        logic valid;
        logic isBD;
        excCode cause;
        word pc;
        word badVAddr;
    } excReq;

    typedef struct packed {
        logic jump;
        word address;
    } redirect;

endpackage

//--- src/irqSync.sv
`timescale 1ns/100ps

module irqSync (
    input logic clk,
    input logic reset,
    input logic line,
    output logic synced
);

    logic meta;    // First stage, may go metastable

    always_ff @(posedge clk) begin
        if (reset) begin
            meta <= 1'b0;
            synced <= 1'b0;
        end else begin
            meta <= line;
            synced <= meta;
        end
    end

endmodule

//--- src/excArbiter.sv
`timescale 1ns/100ps

module excArbiter (
    input cp0Pkg::excReq stageExc [cp0Pkg::numStages],
    output cp0Pkg::excReq selExc,
    output logic pipeExcPending
);

    // Later stage holds the older instruction, so higher index wins
    always_comb begin
        selExc = stageExc[0];
        for (int i = 1; i < cp0Pkg::numStages; i++) begin
            if (stageExc[i].valid) begin
                selExc = stageExc[i];
            end
        end
    end

    always_comb begin
        pipeExcPending = 1'b0;
        for (int i = 0; i < cp0Pkg::numStages; i++) begin
            pipeExcPending = pipeExcPending | stageExc[i].valid;
        end
    end

endmodule

//--- src/cp0Timer.sv
`timescale 1ns/100ps

module cp0Timer (
    input logic clk,
    input logic reset,
    input logic writeEnable,
    input cp0Pkg::regIndex number,
    input cp0Pkg::word writeData,
    input logic writeBlocked,
    input logic clearTimer,
    output cp0Pkg::word count,
    output cp0Pkg::word compare,
    output logic timerIrq
);

    logic phase;    // Count advances when set
    logic writeAccept;
    logic countWrite;
    logic compareWrite;
    logic match;

    assign writeAccept = writeEnable && !writeBlocked;
    assign countWrite = writeAccept && (number == cp0Pkg::regCount);
    assign compareWrite = writeAccept && (number == cp0Pkg::regCompare);

    // Zero Compare never fires
    assign match = (count == compare) && (compare != '0);

    always_ff @(posedge clk) begin
        if (reset) begin
            phase <= 1'b0;
            count <= '0;
            compare <= '0;
        end else begin
            phase <= ~phase;
            if (countWrite) begin
                count <= writeData;
            end else begin
                count <= count + cp0Pkg::word'(phase);
            end
            if (compareWrite) begin
                compare <= writeData;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            timerIrq <= 1'b0;
        end else if (clearTimer) begin
            timerIrq <= 1'b0;    // Clear wins over a fresh match
        end else if (match) begin
            timerIrq <= 1'b1;
        end
    end

endmodule

//--- src/cp0Regs.sv
`timescale 1ns/100ps

module cp0Regs (
    input logic clk,
    input logic reset,
    input logic writeEnable,
    input cp0Pkg::regIndex number,
    input cp0Pkg::word writeData,
    output cp0Pkg::word readData,
    input cp0Pkg::excReq selExc,
    input logic pipeExcPending,
    input cp0Pkg::irqVec irq,
    input cp0Pkg::word count,
    input cp0Pkg::word compare,
    input logic timerIrq,
    output logic clearTimer,
    output logic writeBlocked,
    output cp0Pkg::redirect redir,
    output logic interruptNow
);

    cp0Pkg::word epc;
    cp0Pkg::word status;
    cp0Pkg::word cause;
    cp0Pkg::word badVAddr;

    logic exl;
    logic isEret;
    logic takeExc;
    logic takeEret;
    logic writeAccept;
    logic [7:0] irqSource;
    logic irqEnabled;

    assign exl = status[cp0Pkg::bitExl];
    assign isEret = (selExc.cause == cp0Pkg::causeEret);

    // Entry only from normal level, return only from exception level
    assign takeExc = selExc.valid && !isEret && !exl;
    assign takeEret = selExc.valid && isEret && exl;

    // Any request in flight swallows the register write
    assign writeBlocked = selExc.valid;
    assign writeAccept = writeEnable && !writeBlocked;

    always_comb begin
        redir.jump = takeExc || takeEret;
        redir.address = takeEret ? epc : cp0Pkg::handlerAddress;
    end

    always_comb begin
        case (number)
            cp0Pkg::regBadVAddr: readData = badVAddr;
            cp0Pkg::regCount: readData = count;
            cp0Pkg::regCompare: readData = compare;
            cp0Pkg::regStatus: readData = status;
            cp0Pkg::regCause: readData = cause;
            cp0Pkg::regEpc: readData = epc;
            cp0Pkg::regPrId: readData = cp0Pkg::prIdValue;
            default: readData = '0;
        endcase
    end

    // Timer shares IP7 with line 15
    assign irqSource = {cause[15] | timerIrq, cause[14:8]};
    assign irqEnabled = status[cp0Pkg::bitIe] && !exl && !pipeExcPending;
    assign interruptNow = irqEnabled && |(irqSource & status[15:8]);

    always_ff @(posedge clk) begin
        if (reset) begin
            epc <= '0;
            status <= cp0Pkg::statusReset;
            cause <= '0;
            badVAddr <= '0;
        end else begin
            cause[15:10] <= irq;    // IP follows the lines every cycle

            if (takeExc) begin
                badVAddr <= selExc.badVAddr;
                cause[cp0Pkg::bitBd] <= selExc.isBD;
                cause[6:2] <= selExc.cause;
                if (selExc.isBD) begin
                    epc <= selExc.pc - cp0Pkg::word'(4);    // Point at the branch
                end else begin
                    epc <= selExc.pc;
                end
                status[cp0Pkg::bitExl] <= 1'b1;
            end else if (takeEret) begin
                status[cp0Pkg::bitExl] <= 1'b0;
            end else if (writeAccept) begin
                case (number)
                    cp0Pkg::regBadVAddr: badVAddr <= writeData;
                    cp0Pkg::regStatus: status <= writeData;
                    cp0Pkg::regEpc: epc <= writeData;
                    cp0Pkg::regCause: begin
                        cause[31:16] <= writeData[31:16];
                        cause[9:0] <= writeData[9:0];
                    end
                    default: ;
                endcase
            end
        end
    end

    // One-cycle pulse after a Compare write
    always_ff @(posedge clk) begin
        if (reset) begin
            clearTimer <= 1'b0;
        end else begin
            clearTimer <= writeAccept && (number == cp0Pkg::regCompare);
        end
    end

endmodule

//--- src/exceptionUnit.sv
`timescale 1ns/100ps

module exceptionUnit (
    input logic clk,
    input logic reset,
    input logic writeEnable,
    input cp0Pkg::regIndex number,
    input cp0Pkg::word writeData,
    output cp0Pkg::word readData,
    input cp0Pkg::excReq stageExc [cp0Pkg::numStages],
    input cp0Pkg::irqVec externalIrq,
    output cp0Pkg::redirect redir,
    output logic interruptNow
);

    cp0Pkg::irqVec irqSynced;
    cp0Pkg::excReq selExc;
    logic pipeExcPending;
    cp0Pkg::word count;
    cp0Pkg::word compare;
    logic timerIrq;
    logic clearTimer;
    logic writeBlocked;

    // One lane per external line
    for (genvar i = 0; i < cp0Pkg::numIrq; i++) begin : irqLanes
        irqSync i_irqSync (
            .clk(clk),
            .reset(reset),
            .line(externalIrq[i]),
            .synced(irqSynced[i])
        );
    end

    excArbiter i_excArbiter (
        .stageExc(stageExc),
        .selExc(selExc),
        .pipeExcPending(pipeExcPending)
    );

    cp0Timer i_cp0Timer (
        .clk(clk),
        .reset(reset),
        .writeEnable(writeEnable),
        .number(number),
        .writeData(writeData),
        .writeBlocked(writeBlocked),
        .clearTimer(clearTimer),
        .count(count),
        .compare(compare),
        .timerIrq(timerIrq)
    );

    cp0Regs i_cp0Regs (
        .clk(clk),
        .reset(reset),
        .writeEnable(writeEnable),
        .number(number),
        .writeData(writeData),
        .readData(readData),
        .selExc(selExc),
        .pipeExcPending(pipeExcPending),
        .irq(irqSynced),
        .count(count),
        .compare(compare),
        .timerIrq(timerIrq),
        .clearTimer(clearTimer),
        .writeBlocked(writeBlocked),
        .redir(redir),
        .interruptNow(interruptNow)
    );

endmodule

//--- verif/exceptionUnitTb.sv
`timescale 1ns/100ps

module exceptionUnitTb;

    typedef struct packed {
        logic we;
        cp0Pkg::regIndex num;
        cp0Pkg::word data;
        cp0Pkg::excReq [cp0Pkg::numStages-1:0] exc;    // Index 0 is fetch
        cp0Pkg::irqVec irq;
        logic chkRead;
        cp0Pkg::word expRead;
        cp0Pkg::redirect expRedir;
        logic expIrq;
        int waitMax;    // Nonzero means wait for expIrq
    } stepRow;

    logic clk;
    logic reset;
    logic writeEnable;
    cp0Pkg::regIndex number;
    cp0Pkg::word writeData;
    cp0Pkg::word readData;
    cp0Pkg::excReq stageExc [cp0Pkg::numStages];
    cp0Pkg::irqVec externalIrq;
    cp0Pkg::redirect redir;
    logic interruptNow;

    stepRow steps[$];
    cp0Pkg::word lcgState = 32'ha9af80f9;
    cp0Pkg::irqVec irqHold;    // Line state for rows being built
    logic intHold;
    int cycles = 0;
    int cycleLimit = 0;

    exceptionUnit i_exceptionUnit (
        .clk(clk),
        .reset(reset),
        .writeEnable(writeEnable),
        .number(number),
        .writeData(writeData),
        .readData(readData),
        .stageExc(stageExc),
        .externalIrq(externalIrq),
        .redir(redir),
        .interruptNow(interruptNow)
    );

    always #4 clk = ~clk;    // 8 ns period

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycleLimit > 0 && cycles >= cycleLimit) begin
            failRun("run exceeded the cycle limit without finishing");
        end
    end

    task automatic failRun(input string why);
        $display("%s", why);
        $display("RESULT: FAIL");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic checkWord(input string name, input cp0Pkg::word got, input cp0Pkg::word exp);
        if (got !== exp) begin
            failRun($sformatf("mismatch %s: got %h expected %h", name, got, exp));
        end
    endtask

    // Address only matters when a jump is expected
    task automatic checkRedirect(input cp0Pkg::redirect got, input cp0Pkg::redirect exp);
        if (got.jump !== exp.jump || (exp.jump && got.address !== exp.address)) begin
            failRun($sformatf("mismatch redir: got %h expected %h", got, exp));
        end
    endtask

    task automatic checkBit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            failRun($sformatf("mismatch %s: got %h expected %h", name, got, exp));
        end
    endtask

    function automatic cp0Pkg::word nextRand();
        lcgState = lcgState * 32'd1664525 + 32'd1013904223;
        return lcgState;
    endfunction

    function automatic cp0Pkg::excReq makeExc(input logic isBD, input cp0Pkg::excCode cause);
        cp0Pkg::excReq e;
        e.valid = 1'b1;
        e.isBD = isBD;
        e.cause = cause;
        e.pc = nextRand() & 32'hfffffffc;    // Word aligned
        e.badVAddr = nextRand();
        return e;
    endfunction

    function automatic cp0Pkg::excReq makeEret();
        cp0Pkg::excReq e;
        e = '0;
        e.valid = 1'b1;
        e.cause = cp0Pkg::causeEret;
        return e;
    endfunction

    function automatic cp0Pkg::redirect jumpTo(input cp0Pkg::word address);
        cp0Pkg::redirect r;
        r.jump = 1'b1;
        r.address = address;
        return r;
    endfunction

    // Branch address for a delay slot
    function automatic cp0Pkg::word epcOf(input cp0Pkg::excReq e);
        return e.isBD ? e.pc - 32'd4 : e.pc;
    endfunction

    // BD at 31, ExcCode at 6..2
    function automatic cp0Pkg::word causeValue(input logic isBD, input cp0Pkg::excCode code);
        return {isBD, 24'h0, code, 2'b00};
    endfunction

    function automatic stepRow blankRow();
        stepRow r;
        r = '0;
        r.irq = irqHold;
        r.expIrq = intHold;
        return r;
    endfunction

    task automatic pushRead(input cp0Pkg::regIndex num, input cp0Pkg::word exp);
        stepRow r;
        r = blankRow();
        r.num = num;
        r.chkRead = 1'b1;
        r.expRead = exp;
        steps.push_back(r);
    endtask

    task automatic pushWrite(input cp0Pkg::regIndex num, input cp0Pkg::word data);
        stepRow r;
        r = blankRow();
        r.we = 1'b1;
        r.num = num;
        r.data = data;
        steps.push_back(r);
    endtask

    task automatic pushIdle();
        steps.push_back(blankRow());
    endtask

    task automatic pushWait(input cp0Pkg::regIndex num, input cp0Pkg::word exp, input int limit);
        stepRow r;
        r = blankRow();
        r.num = num;
        r.chkRead = 1'b1;
        r.expRead = exp;
        r.expIrq = 1'b1;
        r.waitMax = limit;
        steps.push_back(r);
    endtask

    task automatic pushExc(input cp0Pkg::excReq e0, input cp0Pkg::excReq e1,
                           input cp0Pkg::excReq e2, input cp0Pkg::redirect exp);
        stepRow r;
        r = blankRow();
        r.exc = {e2, e1, e0};
        r.expRedir = exp;
        r.expIrq = 1'b0;    // Pending request masks interrupts
        steps.push_back(r);
    endtask

    task automatic buildTable();
        cp0Pkg::excReq e0;
        cp0Pkg::excReq e1;
        cp0Pkg::excReq e2;
        cp0Pkg::excReq none;
        cp0Pkg::redirect noJump;
        cp0Pkg::word v;
        none = '0;
        noJump = '0;
        irqHold = '0;
        intHold = 1'b0;

        pushRead(cp0Pkg::regStatus, 32'h0000ff02);
        pushRead(cp0Pkg::regPrId, 32'hdeadbeef);
        v = nextRand();
        pushWrite(cp0Pkg::regEpc, v);
        pushRead(cp0Pkg::regEpc, v);
        pushWrite(cp0Pkg::regCause, 32'hffffffff);
        pushRead(cp0Pkg::regCause, 32'hffff03ff);    // IP bits keep the line state
        pushWrite(cp0Pkg::regCause, 32'h0);
        pushWrite(cp0Pkg::regStatus, 32'h0000ff00);

        // Fetch exception, then one ignored under EXL
        e0 = makeExc(1'b0, cp0Pkg::causeAdEL);
        pushExc(e0, none, none, jumpTo(cp0Pkg::handlerAddress));
        pushRead(cp0Pkg::regEpc, e0.pc);
        pushRead(cp0Pkg::regBadVAddr, e0.badVAddr);
        pushRead(cp0Pkg::regCause, causeValue(1'b0, cp0Pkg::causeAdEL));
        pushRead(cp0Pkg::regStatus, 32'h0000ff02);
        e1 = makeExc(1'b1, cp0Pkg::causeSys);
        pushExc(e1, none, none, noJump);
        pushRead(cp0Pkg::regEpc, e0.pc);
        pushRead(cp0Pkg::regBadVAddr, e0.badVAddr);
        pushRead(cp0Pkg::regCause, causeValue(1'b0, cp0Pkg::causeAdEL));
        pushExc(none, makeEret(), none, jumpTo(e0.pc));
        pushRead(cp0Pkg::regStatus, 32'h0000ff00);
        e0 = makeExc(1'b1, cp0Pkg::causeOv);    // Delay slot
        pushExc(e0, none, none, jumpTo(cp0Pkg::handlerAddress));
        pushRead(cp0Pkg::regEpc, epcOf(e0));
        pushRead(cp0Pkg::regCause, causeValue(1'b1, cp0Pkg::causeOv));
        pushExc(makeEret(), none, none, jumpTo(epcOf(e0)));

        // Oldest stage wins
        e0 = makeExc(1'b0, cp0Pkg::causeAdEL);
        e1 = makeExc(1'b1, cp0Pkg::causeOv);
        e2 = makeExc(1'b0, cp0Pkg::causeSys);
        pushExc(e0, e1, e2, jumpTo(cp0Pkg::handlerAddress));
        pushRead(cp0Pkg::regEpc, epcOf(e2));
        pushRead(cp0Pkg::regBadVAddr, e2.badVAddr);
        pushRead(cp0Pkg::regCause, causeValue(1'b0, cp0Pkg::causeSys));
        pushExc(none, none, makeEret(), jumpTo(epcOf(e2)));
        e0 = makeExc(1'b1, cp0Pkg::causeAdEL);
        e1 = makeExc(1'b1, cp0Pkg::causeOv);
        pushExc(e0, e1, none, jumpTo(cp0Pkg::handlerAddress));
        pushRead(cp0Pkg::regEpc, epcOf(e1));
        pushRead(cp0Pkg::regCause, causeValue(1'b1, cp0Pkg::causeOv));
        pushRead(cp0Pkg::regBadVAddr, e1.badVAddr);
        pushExc(makeEret(), none, none, jumpTo(epcOf(e1)));

        // Line 10 reaches interruptNow after three cycles
        pushWrite(cp0Pkg::regStatus, 32'h0000ff01);
        irqHold = 6'b000001;
        pushRead(cp0Pkg::regStatus, 32'h0000ff01);
        pushIdle();
        pushIdle();
        intHold = 1'b1;
        pushRead(cp0Pkg::regCause, causeValue(1'b1, cp0Pkg::causeOv) | 32'h00000400);
        e2 = makeExc(1'b0, cp0Pkg::causeInt);
        pushExc(none, none, e2, jumpTo(cp0Pkg::handlerAddress));
        pushExc(makeEret(), none, none, jumpTo(epcOf(e2)));
        pushIdle();
        pushWrite(cp0Pkg::regStatus, 32'h0000fb01);    // Mask IM bit 10
        intHold = 1'b0;
        pushRead(cp0Pkg::regStatus, 32'h0000fb01);
        irqHold = '0;
        pushIdle();
        pushIdle();
        pushIdle();
        pushWrite(cp0Pkg::regStatus, 32'h0000ff01);
        pushRead(cp0Pkg::regStatus, 32'h0000ff01);

        // Timer interrupt and its clear
        pushWrite(cp0Pkg::regCount, 32'h0);
        pushWrite(cp0Pkg::regCompare, 32'd10);
        pushWait(cp0Pkg::regCompare, 32'd10, 30);
        intHold = 1'b1;
        pushWrite(cp0Pkg::regCompare, 32'h100);
        pushIdle();
        intHold = 1'b0;
        pushRead(cp0Pkg::regCompare, 32'h100);
    endtask

    task automatic driveRow(input stepRow r);
        writeEnable = r.we;
        number = r.num;
        writeData = r.data;
        externalIrq = r.irq;
        for (int i = 0; i < cp0Pkg::numStages; i++) begin
            stageExc[i] = r.exc[i];
        end
    endtask

    task automatic checkRow(input stepRow r);
        if (r.chkRead) begin
            checkWord("readData", readData, r.expRead);
        end
        checkRedirect(redir, r.expRedir);
        checkBit("interruptNow", interruptNow, r.expIrq);
    endtask

    // Inputs stay as driven while waiting
    task automatic waitInterrupt(input stepRow r);
        int n;
        n = 0;
        while (interruptNow !== r.expIrq && n < r.waitMax) begin
            @(negedge clk);
            #2;
            n++;
        end
        if (interruptNow !== r.expIrq) begin
            failRun($sformatf("interruptNow did not assert within %0d cycles", r.waitMax));
        end
    endtask

    initial begin
        clk = 1'b0;
        reset = 1'b1;
        writeEnable = 1'b0;
        number = '0;
        writeData = '0;
        externalIrq = '0;
        for (int i = 0; i < cp0Pkg::numStages; i++) begin
            stageExc[i] = '0;
        end
        buildTable();
        cycleLimit = steps.size() * 4 + 200;

        repeat (4) @(negedge clk);
        reset = 1'b0;

        for (int i = 0; i < steps.size(); i++) begin
            @(negedge clk);
            driveRow(steps[i]);
            #2;    // Settle before sampling
            if (steps[i].waitMax != 0) begin
                waitInterrupt(steps[i]);
            end
            checkRow(steps[i]);
        end

        @(negedge clk);
        driveRow(blankRow());
        $display("RESULT: PASS");
        $finish;
    end

endmodule

//--- list.f
src/cp0Pkg.sv
src/irqSync.sv
src/excArbiter.sv
src/cp0Timer.sv
src/cp0Regs.sv
src/exceptionUnit.sv
verif/exceptionUnitTb.sv

//--- run.sh
#!/usr/bin/env bash
# Builds and runs the exception unit testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f list.f --top-module exceptionUnitTb \
    --Mdir obj_dir -o simv > build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }

./obj_dir/simv > sim.log 2>&1
cat sim.log

! grep -q "RESULT: FAIL" sim.log && grep -q "RESULT: PASS" sim.log \
    && echo "simulation passed" || { echo "simulation failed"; exit 1; }
